// File: rtl/periph_params.svh
// Peripheral subsystem parameters.
// Address map, bus widths and device sizes shared by all blocks.

`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Bus geometry.
`define BUS_AW 32
`define BUS_DW 32
`define BUS_BE 4

// RAM depth in words.
`define RAM_WORDS 1024

//////////////////////////////////////////////////////////////////////
// Address map, upper 16 address bits select the device.
//////////////////////////////////////////////////////////////////////

`define RAM_REGION   16'h0010
`define GPIO_REGION  16'h8000
`define TIMER_REGION 16'h8001
`define PWM_REGION   16'h8002

// GPIO widths.
`define GPI_W 8
`define GPO_W 16

// PWM bank.
`define PWM_CH    4
`define PWM_CTR_W 8

`endif

// File: rtl/periph_pkg.sv
// Peripheral bus types.
// Request and response structs, address views and the byte-merge helper.

`include "periph_params.svh"

package periph_pkg;

  // Memory view of an address.
  typedef struct packed {
    logic [15:0] region;
    logic [13:0] word_idx;
    logic [1:0]  byte_off;
  } mem_addr_t;

  // Register view of an address.
  typedef struct packed {
    logic [15:0] region;
    logic [7:0]  unused;
    logic [5:0]  reg_idx;
    logic [1:0]  byte_off;
  } reg_addr_t;

  typedef union packed {
    mem_addr_t mem;
    reg_addr_t regs;
  } bus_addr_u;

  typedef struct packed {
    logic               req;
    logic               we;
    logic [`BUS_BE-1:0] be;
    bus_addr_u          addr;
    logic [`BUS_DW-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic               rvalid;
    logic               err;
    logic [`BUS_DW-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    DEV_RAM   = 2'd0,
    DEV_GPIO  = 2'd1,
    DEV_TIMER = 2'd2,
    DEV_PWM   = 2'd3
  } dev_sel_e;

  // Replace the enabled bytes of the old word.
  function automatic logic [`BUS_DW-1:0] merge_bytes(input logic [`BUS_DW-1:0] old_w,
                                                     input logic [`BUS_DW-1:0] new_w,
                                                     input logic [`BUS_BE-1:0] be);
    logic [`BUS_DW-1:0] res;
    res = old_w;
    for (int i = 0; i < `BUS_BE; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: rtl/bus_decoder.sv
// Bus decoder.
// Selects a device from the address region, flags illegal accesses
// and returns the one-cycle response.

`timescale 1ns/100ps
`include "periph_params.svh"

module bus_decoder
  import periph_pkg::*;
(
  input  logic               clk_sys_i,
  input  logic               rst_n_i,

  input  bus_req_t           bus_req_i,

  output bus_req_t           ram_req_o,
  output bus_req_t           gpio_req_o,
  output bus_req_t           pwm_req_o,
  output bus_req_t           timer_req_o,

  input  logic [`BUS_DW-1:0] ram_rdata_i,
  input  logic [`BUS_DW-1:0] gpio_rdata_i,
  input  logic [`BUS_DW-1:0] pwm_rdata_i,
  input  logic [`BUS_DW-1:0] timer_rdata_i,

  output bus_rsp_t           bus_rsp_o
);

  localparam logic [13:0] RAM_LIMIT = 14'(`RAM_WORDS);

  dev_sel_e dev_sel;
  logic     region_hit;
  logic     access_err;
  logic     access_ok;

  // Response cycle state.
  logic     rsp_valid_q;
  logic     rsp_err_q;
  logic     rsp_we_q;
  dev_sel_e rsp_sel_q;

  //////////////////////////////////////////////////////////////////////
  // Address decode.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    region_hit = 1'b1;
    dev_sel    = DEV_RAM;
    case (bus_req_i.addr.mem.region)
      `RAM_REGION:   dev_sel = DEV_RAM;
      `GPIO_REGION:  dev_sel = DEV_GPIO;
      `TIMER_REGION: dev_sel = DEV_TIMER;
      `PWM_REGION:   dev_sel = DEV_PWM;
      default:       region_hit = 1'b0;
    endcase
  end

  // Unknown region, or a word beyond the end of the RAM.
  assign access_err = bus_req_i.req &
                      (~region_hit |
                       ((dev_sel == DEV_RAM) && (bus_req_i.addr.mem.word_idx >= RAM_LIMIT)));
  assign access_ok  = bus_req_i.req & ~access_err;

  // Forward the request, strobe only to the selected device.
  always_comb begin
    ram_req_o       = bus_req_i;
    gpio_req_o      = bus_req_i;
    pwm_req_o       = bus_req_i;
    timer_req_o     = bus_req_i;
    ram_req_o.req   = access_ok && (dev_sel == DEV_RAM);
    gpio_req_o.req  = access_ok && (dev_sel == DEV_GPIO);
    pwm_req_o.req   = access_ok && (dev_sel == DEV_PWM);
    timer_req_o.req = access_ok && (dev_sel == DEV_TIMER);
  end

  //////////////////////////////////////////////////////////////////////
  // Response.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
      rsp_we_q    <= 1'b0;
      rsp_sel_q   <= DEV_RAM;
    end else begin
      rsp_valid_q <= bus_req_i.req;
      rsp_err_q   <= access_err;
      rsp_we_q    <= bus_req_i.req & bus_req_i.we;
      rsp_sel_q   <= dev_sel;
    end
  end

  always_comb begin
    bus_rsp_o.rvalid = rsp_valid_q;
    bus_rsp_o.err    = rsp_err_q;
    bus_rsp_o.rdata  = '0;
    // Writes and errors return zero data.
    if (!rsp_err_q && !rsp_we_q) begin
      case (rsp_sel_q)
        DEV_RAM:   bus_rsp_o.rdata = ram_rdata_i;
        DEV_GPIO:  bus_rsp_o.rdata = gpio_rdata_i;
        DEV_TIMER: bus_rsp_o.rdata = timer_rdata_i;
        DEV_PWM:   bus_rsp_o.rdata = pwm_rdata_i;
        default:   bus_rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

// File: rtl/sram_bank.sv
// Word RAM.
// Byte-enabled writes and a registered read port.

`timescale 1ns/100ps
`include "periph_params.svh"

module sram_bank
  import periph_pkg::*;
(
  input  logic               clk_sys_i,
  input  logic               rst_n_i,
  input  bus_req_t           req_i,
  output logic [`BUS_DW-1:0] rdata_o
);

  localparam int unsigned RAM_AW = $clog2(`RAM_WORDS);

  logic [`BUS_DW-1:0] mem_q [`RAM_WORDS];
  logic [RAM_AW-1:0]  word_idx;
  logic [`BUS_DW-1:0] rdata_q;
  logic               wr_en;
  logic               rd_en;

  // Decoder has already rejected indices past the end.
  assign word_idx = req_i.addr.mem.word_idx[RAM_AW-1:0];
  assign wr_en    = req_i.req & req_i.we;
  assign rd_en    = req_i.req & ~req_i.we;

  always_ff @(posedge clk_sys_i) begin
    if (wr_en) begin
      mem_q[word_idx] <= merge_bytes(mem_q[word_idx], req_i.wdata, req_i.be);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: rtl/gpio_regs.sv
// GPIO registers.
// Output register at index 0, synchronized inputs at index 1.

`timescale 1ns/100ps
`include "periph_params.svh"

module gpio_regs
  import periph_pkg::*;
(
  input  logic               clk_sys_i,
  input  logic               rst_n_i,
  input  bus_req_t           req_i,
  output logic [`BUS_DW-1:0] rdata_o,
  input  logic [`GPI_W-1:0]  gp_i,
  output logic [`GPO_W-1:0]  gp_o
);

  logic [`GPO_W-1:0]  gpo_q;
  logic [`GPI_W-1:0]  gpi_meta_q;
  logic [`GPI_W-1:0]  gpi_sync_q;
  logic [`BUS_DW-1:0] gpo_merged;
  logic [`BUS_DW-1:0] rdata_q;
  logic [5:0]         reg_idx;

  assign reg_idx    = req_i.addr.regs.reg_idx;
  assign gpo_merged = merge_bytes(`BUS_DW'(gpo_q), req_i.wdata, req_i.be);

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rdata_q    <= '0;
    end else begin
      // Two-flop input synchronizer.
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      if (req_i.req && req_i.we && (reg_idx == 6'd0)) begin
        gpo_q <= gpo_merged[`GPO_W-1:0];
      end
      if (req_i.req && !req_i.we) begin
        case (reg_idx)
          6'd0:    rdata_q <= `BUS_DW'(gpo_q);
          6'd1:    rdata_q <= `BUS_DW'(gpi_sync_q);
          default: rdata_q <= '0;
        endcase
      end
    end
  end

  assign gp_o    = gpo_q;
  assign rdata_o = rdata_q;

endmodule

// File: rtl/pwm_bank.sv
// PWM channel bank.
// One config register and one free-running counter per channel,
// output high while the counter is below the duty.

`timescale 1ns/100ps
`include "periph_params.svh"

module pwm_bank
  import periph_pkg::*;
(
  input  logic               clk_sys_i,
  input  logic               rst_n_i,
  input  bus_req_t           req_i,
  output logic [`BUS_DW-1:0] rdata_o,
  output logic [`PWM_CH-1:0] pwm_o
);

  localparam int unsigned CH_W = $clog2(`PWM_CH);

  // Register layout, period in 15:8 and duty in 7:0.
  typedef struct packed {
    logic [`PWM_CTR_W-1:0] period;
    logic [`PWM_CTR_W-1:0] duty;
  } pwm_cfg_t;

  pwm_cfg_t              cfg_q [`PWM_CH];
  logic [`PWM_CTR_W-1:0] ctr_q [`PWM_CH];
  logic [`PWM_CH-1:0]    pwm_q;
  logic [`BUS_DW-1:0]    rdata_q;
  logic [5:0]            reg_idx;
  logic                  idx_ok;

  assign reg_idx = req_i.addr.regs.reg_idx;
  assign idx_ok  = (reg_idx < 6'(`PWM_CH));

  for (genvar ch = 0; ch < `PWM_CH; ch++) begin : gen_ch
    logic [`BUS_DW-1:0] merged;

    assign merged = merge_bytes(`BUS_DW'(cfg_q[ch]), req_i.wdata, req_i.be);

    always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cfg_q[ch] <= '0;
        ctr_q[ch] <= '0;
        pwm_q[ch] <= 1'b0;
      end else begin
        if (req_i.req && req_i.we && (reg_idx == 6'(ch))) begin
          cfg_q[ch] <= merged[$bits(pwm_cfg_t)-1:0];
        end
        // Wrap at the period, also catches a period lowered below the count.
        if (ctr_q[ch] >= cfg_q[ch].period) begin
          ctr_q[ch] <= '0;
        end else begin
          ctr_q[ch] <= ctr_q[ch] + 1'b1;
        end
        pwm_q[ch] <= (ctr_q[ch] < cfg_q[ch].duty);
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (req_i.req && !req_i.we) begin
      rdata_q <= idx_ok ? `BUS_DW'(cfg_q[reg_idx[CH_W-1:0]]) : '0;
    end
  end

  assign pwm_o   = pwm_q;
  assign rdata_o = rdata_q;

endmodule

// File: rtl/mtimer.sv
// Machine timer.
// 64-bit free-running mtime with a compare register and a level interrupt.

`timescale 1ns/100ps
`include "periph_params.svh"

module mtimer
  import periph_pkg::*;
(
  input  logic               clk_sys_i,
  input  logic               rst_n_i,
  input  bus_req_t           req_i,
  output logic [`BUS_DW-1:0] rdata_o,
  output logic               timer_irq_o
);

  logic [63:0]        mtime_q;
  logic [63:0]        mtime_d;
  logic [63:0]        mtimecmp_q;
  logic [63:0]        mtimecmp_d;
  logic               irq_q;
  logic [`BUS_DW-1:0] rdata_q;
  logic [5:0]         reg_idx;
  logic               wr_en;

  assign reg_idx = req_i.addr.regs.reg_idx;
  assign wr_en   = req_i.req & req_i.we;

  //////////////////////////////////////////////////////////////////////
  // Next state.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (reg_idx)
        // A write to mtime replaces the increment for that cycle.
        6'd0: mtime_d = {mtime_q[63:32],
                         merge_bytes(mtime_q[31:0], req_i.wdata, req_i.be)};
        6'd1: mtime_d = {merge_bytes(mtime_q[63:32], req_i.wdata, req_i.be),
                         mtime_q[31:0]};
        6'd2: mtimecmp_d = {mtimecmp_q[63:32],
                            merge_bytes(mtimecmp_q[31:0], req_i.wdata, req_i.be)};
        6'd3: mtimecmp_d = {merge_bytes(mtimecmp_q[63:32], req_i.wdata, req_i.be),
                            mtimecmp_q[31:0]};
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      rdata_q    <= '0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      // Interrupt lags the compare by one cycle.
      irq_q      <= (mtime_q >= mtimecmp_q);
      if (req_i.req && !req_i.we) begin
        case (reg_idx)
          6'd0:    rdata_q <= mtime_q[31:0];
          6'd1:    rdata_q <= mtime_q[63:32];
          6'd2:    rdata_q <= mtimecmp_q[31:0];
          6'd3:    rdata_q <= mtimecmp_q[63:32];
          default: rdata_q <= '0;
        endcase
      end
    end
  end

  assign timer_irq_o = irq_q;
  assign rdata_o     = rdata_q;

endmodule

// File: rtl/periph_system.sv
// Peripheral subsystem top level.
// Bus decoder with RAM, GPIO, PWM bank and machine timer behind it.

`timescale 1ns/100ps
`include "periph_params.svh"

module periph_system
  import periph_pkg::*;
(
  input  logic               clk_sys_i,
  input  logic               rst_n_i,

  input  bus_req_t           bus_req_i,
  output bus_rsp_t           bus_rsp_o,

  input  logic [`GPI_W-1:0]  gp_i,
  output logic [`GPO_W-1:0]  gp_o,
  output logic [`PWM_CH-1:0] pwm_o,
  output logic               timer_irq_o
);

  // Steered requests.
  bus_req_t ram_req;
  bus_req_t gpio_req;
  bus_req_t pwm_req;
  bus_req_t timer_req;

  // Registered read data from each device.
  logic [`BUS_DW-1:0] ram_rdata;
  logic [`BUS_DW-1:0] gpio_rdata;
  logic [`BUS_DW-1:0] pwm_rdata;
  logic [`BUS_DW-1:0] timer_rdata;

  bus_decoder u_bus_decoder (
    .clk_sys_i    (clk_sys_i),
    .rst_n_i      (rst_n_i),
    .bus_req_i    (bus_req_i),
    .ram_req_o    (ram_req),
    .gpio_req_o   (gpio_req),
    .pwm_req_o    (pwm_req),
    .timer_req_o  (timer_req),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .pwm_rdata_i  (pwm_rdata),
    .timer_rdata_i(timer_rdata),
    .bus_rsp_o    (bus_rsp_o)
  );

  sram_bank u_sram_bank (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (ram_req),
    .rdata_o  (ram_rdata)
  );

  gpio_regs u_gpio_regs (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (gpio_req),
    .rdata_o  (gpio_rdata),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  pwm_bank u_pwm_bank (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (pwm_req),
    .rdata_o  (pwm_rdata),
    .pwm_o    (pwm_o)
  );

  mtimer u_mtimer (
    .clk_sys_i  (clk_sys_i),
    .rst_n_i    (rst_n_i),
    .req_i      (timer_req),
    .rdata_o    (timer_rdata),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// File: verif/periph_props.sv
// Bus response properties.
// Bound to the bus decoder, checks response timing and error data.

`timescale 1ns/100ps

module periph_props
  import periph_pkg::*;
(
  input logic     clk_sys_i,
  input logic     rst_n_i,
  input bus_req_t bus_req_i,
  input bus_rsp_t bus_rsp_o
);

  // Every request is answered in the next cycle.
  rsp_after_req: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    bus_req_i.req |=> bus_rsp_o.rvalid)
    else $error("rvalid missing one cycle after a request");

  // And nothing is answered without one.
  no_rsp_without_req: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    !bus_req_i.req |=> !bus_rsp_o.rvalid)
    else $error("rvalid raised without a request in the previous cycle");

  // Errors carry zero data.
  err_zero_data: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    bus_rsp_o.err |-> (bus_rsp_o.rvalid && (bus_rsp_o.rdata == '0)))
    else $error("error response with nonzero data or without rvalid");

  quiet_in_reset: assert property (@(posedge clk_sys_i)
    !rst_n_i |-> !bus_rsp_o.rvalid)
    else $error("rvalid high during reset");

endmodule

bind bus_decoder periph_props i_props (
  .clk_sys_i(clk_sys_i),
  .rst_n_i  (rst_n_i),
  .bus_req_i(bus_req_i),
  .bus_rsp_o(bus_rsp_o)
);

// File: verif/tb_periph_system.sv
// Testbench for the peripheral subsystem.
// Table-driven bus accesses, then GPIO input, PWM and timer checks.

`timescale 1ns/100ps
`include "periph_params.svh"

module tb_periph_system
  import periph_pkg::*;
();

  localparam int CLK_PERIOD     = 4;
  localparam int N_ENTRIES      = 19;
  localparam int PWM_WIN_CYCLES = 80;
  localparam int MARGIN_CYCLES  = 200;
  localparam int WATCHDOG_CYCLES = N_ENTRIES * 4 + PWM_WIN_CYCLES + MARGIN_CYCLES;
  localparam int RSP_TIMEOUT    = 4;

  typedef struct packed {
    logic               we;
    logic [`BUS_AW-1:0] addr;
    logic [`BUS_BE-1:0] be;
    logic [`BUS_DW-1:0] wdata;
    logic [`BUS_DW-1:0] exp_rdata;
    logic               exp_err;
  } entry_t;

  logic               clk_sys = 1'b0;
  logic               rst_n;
  bus_req_t           bus_req;
  bus_rsp_t           bus_rsp;
  logic [`GPI_W-1:0]  gp_i;
  logic [`GPO_W-1:0]  gp_o;
  logic [`PWM_CH-1:0] pwm_o;
  logic               timer_irq_o;

  entry_t      stim_tab [N_ENTRIES];
  int          n_fill;
  logic [31:0] rng_state;
  int          n_tests  = 0;
  int          n_checks = 0;
  int          n_errors = 0;

  periph_system i_dut (
    .clk_sys_i  (clk_sys),
    .rst_n_i    (rst_n),
    .bus_req_i  (bus_req),
    .bus_rsp_o  (bus_rsp),
    .gp_i       (gp_i),
    .gp_o       (gp_o),
    .pwm_o      (pwm_o),
    .timer_irq_o(timer_irq_o)
  );

  always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers.
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Expected word after a byte-enabled write.
  function automatic logic [31:0] merge_expect(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  be);
    logic [31:0] mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] ram_addr(input logic [13:0] idx);
    return {`RAM_REGION, idx, 2'b00};
  endfunction

  function automatic logic [31:0] reg_addr(input logic [15:0] region, input logic [5:0] idx);
    return {region, 8'h00, idx, 2'b00};
  endfunction

  task automatic add_entry(input logic we, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, input logic [31:0] exp_rdata,
                           input logic exp_err);
    stim_tab[n_fill] = {we, addr, be, wdata, exp_rdata, exp_err};
    n_fill++;
  endtask

  task automatic build_stimulus();
    logic [13:0] ram_idx [4];
    logic [31:0] ram_model [4];
    logic [31:0] w;
    ram_idx = '{14'd0, 14'd3, 14'd512, 14'd1023};
    n_fill = 0;
    for (int s = 0; s < 4; s++) begin
      w = next_rand();
      ram_model[s] = w;
      add_entry(1'b1, ram_addr(ram_idx[s]), 4'hF, w, '0, 1'b0);
    end
    // Partial writes over the full ones.
    w = next_rand();
    ram_model[0] = merge_expect(ram_model[0], w, 4'b0101);
    add_entry(1'b1, ram_addr(ram_idx[0]), 4'b0101, w, '0, 1'b0);
    w = next_rand();
    ram_model[2] = merge_expect(ram_model[2], w, 4'b0110);
    add_entry(1'b1, ram_addr(ram_idx[2]), 4'b0110, w, '0, 1'b0);
    w = next_rand();
    ram_model[3] = merge_expect(ram_model[3], w, 4'b1000);
    add_entry(1'b1, ram_addr(ram_idx[3]), 4'b1000, w, '0, 1'b0);
    for (int s = 0; s < 4; s++) begin
      add_entry(1'b0, ram_addr(ram_idx[s]), 4'hF, '0, ram_model[s], 1'b0);
    end
    // Past the RAM end and unmapped regions.
    add_entry(1'b0, ram_addr(14'(`RAM_WORDS)), 4'hF, '0, '0, 1'b1);
    add_entry(1'b0, 32'h4000_0040, 4'hF, '0, '0, 1'b1);
    add_entry(1'b1, 32'h0011_0000, 4'hF, next_rand(), '0, 1'b1);
    add_entry(1'b0, ram_addr(ram_idx[0]), 4'hF, '0, ram_model[0], 1'b0);
    // GPIO output, byte by byte.
    add_entry(1'b1, reg_addr(`GPIO_REGION, 6'd0), 4'b0001, 32'h1234_56C3, '0, 1'b0);
    add_entry(1'b1, reg_addr(`GPIO_REGION, 6'd0), 4'b0010, 32'hDEAD_A5FF, '0, 1'b0);
    add_entry(1'b0, reg_addr(`GPIO_REGION, 6'd0), 4'hF, '0, 32'h0000_A5C3, 1'b0);
    add_entry(1'b0, reg_addr(`GPIO_REGION, 6'd5), 4'hF, '0, '0, 1'b0);
  endtask

  // Starts and ends on a falling edge.
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output bus_rsp_t rsp);
    int waited;
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.be    = be;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    @(negedge clk_sys);
    bus_req.req = 1'b0;
    waited = 0;
    while (!bus_rsp.rvalid && waited < RSP_TIMEOUT) begin
      @(negedge clk_sys);
      waited++;
    end
    if (!bus_rsp.rvalid) begin
      n_errors++;
      $display("no response from the DUT for the access at %08h", addr);
    end else if (waited != 0) begin
      n_errors++;
      $display("response for the access at %08h came %0d cycles late", addr, waited);
    end
    rsp = bus_rsp;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks.
  //////////////////////////////////////////////////////////////////////

  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %t: %s rvalid=%0b err=%0b rdata=%08h, expected rvalid=%0b err=%0b rdata=%08h",
               $time, what, got.rvalid, got.err, got.rdata, exp.rvalid, exp.err, exp.rdata);
    end
  endtask

  task automatic check_gpo(input logic [`GPO_W-1:0] got, input logic [`GPO_W-1:0] exp,
                           input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %t: %s gp_o=%04h, expected %04h", $time, what, got, exp);
    end
  endtask

  task automatic check_pwm(input int got, input int exp, input string what);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("FAIL %t: %s high for %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %t: %s timer_irq_o=%0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_mtime_incr(input logic [31:0] first, input logic [31:0] second);
    n_checks++;
    if (second <= first) begin
      n_errors++;
      $display("FAIL %t: mtime low went from %08h to %08h", $time, first, second);
    end
  endtask

  task automatic reg_write(input logic [15:0] region, input logic [5:0] idx,
                           input logic [31:0] data);
    bus_rsp_t rsp;
    bus_access(1'b1, reg_addr(region, idx), 4'hF, data, rsp);
    check_rsp(rsp, {1'b1, 1'b0, 32'h0}, $sformatf("write to %04h reg %0d", region, idx));
  endtask

  task automatic count_high(input int ch, input int len, output int n);
    n = 0;
    repeat (len) begin
      @(negedge clk_sys);
      if (pwm_o[ch]) begin
        n++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    n_tests++;
    if (n_errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n_errors - err_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence.
  //////////////////////////////////////////////////////////////////////

  initial begin
    bus_rsp_t    rsp;
    logic [31:0] first_mtime;
    int          err_before;
    int          n_high;
    int          waited;
    $timeformat(-9, 1, " ns", 0);
    rst_n     = 1'b0;
    bus_req   = '0;
    gp_i      = '0;
    rng_state = 32'h503f;
    build_stimulus();
    repeat (3) @(negedge clk_sys);
    rst_n = 1'b1;

    err_before = n_errors;
    check_rsp(bus_rsp, '0, "response after reset");
    check_gpo(gp_o, '0, "gp_o after reset");
    check_pwm($countones(pwm_o), 0, "pwm_o after reset");
    check_irq(timer_irq_o, 1'b0, "interrupt after reset");
    finish_test("reset_state", err_before);

    err_before = n_errors;
    for (int i = 0; i < N_ENTRIES; i++) begin
      bus_access(stim_tab[i].we, stim_tab[i].addr, stim_tab[i].be, stim_tab[i].wdata, rsp);
      check_rsp(rsp, {1'b1, stim_tab[i].exp_err, stim_tab[i].exp_rdata},
                $sformatf("entry %0d", i));
    end
    check_gpo(gp_o, 16'hA5C3, "gp_o after byte writes");
    finish_test("bus_table", err_before);

    err_before = n_errors;
    gp_i = 8'h3C;
    repeat (3) @(negedge clk_sys);
    bus_access(1'b0, reg_addr(`GPIO_REGION, 6'd1), 4'hF, '0, rsp);
    check_rsp(rsp, {1'b1, 1'b0, 32'h0000_003C}, "gpio input read");
    finish_test("gpio_input", err_before);

    // Channel 1 period 9 duty 3, channel 2 duty 0, channel 3 duty above period.
    err_before = n_errors;
    reg_write(`PWM_REGION, 6'd1, {16'h0, 8'd9, 8'd3});
    repeat (4) @(negedge clk_sys);
    count_high(1, 10, n_high);
    check_pwm(n_high, 3, "pwm channel 1");
    reg_write(`PWM_REGION, 6'd2, {16'h0, 8'd5, 8'd0});
    reg_write(`PWM_REGION, 6'd3, {16'h0, 8'd4, 8'd200});
    repeat (8) @(negedge clk_sys);
    count_high(2, 6, n_high);
    check_pwm(n_high, 0, "pwm channel 2 duty zero");
    count_high(3, 5, n_high);
    check_pwm(n_high, 5, "pwm channel 3 duty above period");
    count_high(0, 10, n_high);
    check_pwm(n_high, 0, "pwm channel 0 untouched");
    count_high(1, 10, n_high);
    check_pwm(n_high, 3, "pwm channel 1 after other writes");
    bus_access(1'b0, reg_addr(`PWM_REGION, 6'd1), 4'hF, '0, rsp);
    check_rsp(rsp, {1'b1, 1'b0, 32'h0000_0903}, "pwm channel 1 readback");
    finish_test("pwm", err_before);

    err_before = n_errors;
    bus_access(1'b0, reg_addr(`TIMER_REGION, 6'd0), 4'hF, '0, rsp);
    first_mtime = rsp.rdata;
    repeat (6) @(negedge clk_sys);
    bus_access(1'b0, reg_addr(`TIMER_REGION, 6'd0), 4'hF, '0, rsp);
    check_mtime_incr(first_mtime, rsp.rdata);
    finish_test("mtime", err_before);

    err_before = n_errors;
    reg_write(`TIMER_REGION, 6'd3, 32'hFFFF_FFFF);
    reg_write(`TIMER_REGION, 6'd2, 32'h0000_0000);
    repeat (3) @(negedge clk_sys);
    check_irq(timer_irq_o, 1'b0, "interrupt with compare high word all ones");
    // Low word first so the compare never passes through zero.
    reg_write(`TIMER_REGION, 6'd2, 32'h0000_0008);
    reg_write(`TIMER_REGION, 6'd3, 32'h0000_0000);
    waited = 0;
    while (!timer_irq_o && waited < 20) begin
      @(negedge clk_sys);
      waited++;
    end
    check_irq(timer_irq_o, 1'b1, "interrupt with compare at 8");
    reg_write(`TIMER_REGION, 6'd3, 32'hFFFF_FFFF);
    reg_write(`TIMER_REGION, 6'd2, 32'hFFFF_FFFF);
    repeat (3) @(negedge clk_sys);
    check_irq(timer_irq_o, 1'b0, "interrupt after compare back to all ones");
    finish_test("timer_irq", err_before);

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/periph_pkg.sv
rtl/bus_decoder.sv
rtl/sram_bank.sv
rtl/gpio_regs.sv
rtl/pwm_bank.sv
rtl/mtimer.sv
rtl/periph_system.sv
verif/periph_props.sv
verif/tb_periph_system.sv

// File: run.sh
#!/bin/sh
# Build the peripheral subsystem testbench with Verilator and run it.
# The run passes only if the testbench prints its pass message.

verilator --binary --timing --assert -j 0 \
  -f vlog.f --top-module tb_periph_system -o sim_tb \
  && out=$(./obj_dir/sim_tb) \
  ; echo "$out" \
  && echo "$out" | grep -q "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
